// ==== src/arcade_io_pkg.sv ====
/*
 * Scan codes are PS/2 set 2 make codes without the E0 prefix.
 * Bit positions below are shared by the key decoder, the control mapper and the testbench.
 */
`default_nettype none

package arcade_io_pkg;

	// ------------------------------------------------------------------------
	// Keyboard scan codes
	// ------------------------------------------------------------------------
	localparam logic [7:0] sc_up      = 8'h75; // Cursor up
	localparam logic [7:0] sc_down    = 8'h72; // Cursor down
	localparam logic [7:0] sc_left    = 8'h6b;
	localparam logic [7:0] sc_right   = 8'h74;
	localparam logic [7:0] sc_coin    = 8'h76; // Escape
	localparam logic [7:0] sc_start1  = 8'h05; // F1
	localparam logic [7:0] sc_start2  = 8'h06; // F2
	localparam logic [7:0] sc_fire    = 8'h29; // Space
	localparam logic [7:0] sc_barrier = 8'h11; // Alt

	// Held keyboard buttons, one bit per key
	typedef logic [8:0] kb_buttons_t;
	localparam int kb_up      = 0;
	localparam int kb_down    = 1;
	localparam int kb_left    = 2;
	localparam int kb_right   = 3;
	localparam int kb_coin    = 4;
	localparam int kb_start1  = 5;
	localparam int kb_start2  = 6;
	localparam int kb_fire    = 7;
	localparam int kb_barrier = 8;

	// Control word as seen by the game core
	typedef logic [6:0] game_ctrl_t;
	localparam int ctl_coin    = 0;
	localparam int ctl_start1  = 1;
	localparam int ctl_start2  = 2;
	localparam int ctl_left    = 3;
	localparam int ctl_right   = 4;
	localparam int ctl_fire    = 5;
	localparam int ctl_barrier = 6;

	// Joystick port layout with the upper two bits unused here
	typedef logic [7:0] joy_t;
	localparam int joy_right   = 0;
	localparam int joy_left    = 1;
	localparam int joy_down    = 2;
	localparam int joy_up      = 3;
	localparam int joy_fire    = 4;
	localparam int joy_barrier = 5;

	// Default widths
	localparam int COLOR_BITS = 2;  // Per color channel
	localparam int AUDIO_BITS = 12; // Core audio sample

endpackage

`default_nettype wire

// ==== src/key_decoder.sv ====
/*
 * Expects one key event per strobe cycle, with the pressed flag already resolved.
 * Codes that match none of the nine keys are ignored.
 */
`timescale 1ns/10ps
`default_nettype none

module key_decoder (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      key_strobe,
	input  logic [7:0]                key_code,
	input  logic                      key_pressed,
	output arcade_io_pkg::kb_buttons_t kb_buttons
);

	import arcade_io_pkg::*;

	kb_buttons_t key_hit; // One-hot match of the current code
	kb_buttons_t kb_next;

	// ------------------------------------------------------------------------
	// Code match
	// ------------------------------------------------------------------------
	always_comb begin
		key_hit = '0;
		case (key_code)
			sc_up:      key_hit[kb_up]      = 1'b1;
			sc_down:    key_hit[kb_down]    = 1'b1;
			sc_left:    key_hit[kb_left]    = 1'b1;
			sc_right:   key_hit[kb_right]   = 1'b1;
			sc_coin:    key_hit[kb_coin]    = 1'b1;
			sc_start1:  key_hit[kb_start1]  = 1'b1;
			sc_start2:  key_hit[kb_start2]  = 1'b1;
			sc_fire:    key_hit[kb_fire]    = 1'b1;
			sc_barrier: key_hit[kb_barrier] = 1'b1;
			default:    key_hit = '0;       // Unknown key
		endcase
	end

	// Replace only the matching bit with the pressed flag
	always_comb begin
		kb_next = kb_buttons;
		if (key_strobe) begin
			kb_next = (kb_buttons & ~key_hit) | (key_hit & {$bits(kb_buttons_t){key_pressed}});
		end
	end

	// ------------------------------------------------------------------------
	// Held button state
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			kb_buttons <= '0; // All keys released
		end else begin
			kb_buttons <= kb_next;
		end
	end

endmodule

`default_nettype wire

// ==== src/control_mapper.sv ====
/*
 * Joystick bits above joy_barrier are ignored.
 * With rotate set, up and down steer right and left for a rotated monitor.
 */
`timescale 1ns/10ps
`default_nettype none

module control_mapper (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  arcade_io_pkg::kb_buttons_t kb_buttons,
	input  arcade_io_pkg::joy_t        joystick_0,
	input  arcade_io_pkg::joy_t        joystick_1,
	input  logic                       rotate,
	output arcade_io_pkg::game_ctrl_t  game_ctrl
);

	import arcade_io_pkg::*;

	joy_t       joy_any;   // Both ports merged
	game_ctrl_t ctrl_next;
	logic       left_raw;
	logic       right_raw;

	assign joy_any = joystick_0 | joystick_1;

	// ------------------------------------------------------------------------
	// Direction select
	// ------------------------------------------------------------------------
	always_comb begin
		if (rotate) begin
			// Screen turned, so vertical stick moves the ship sideways
			left_raw  = kb_buttons[kb_down] | joy_any[joy_down];
			right_raw = kb_buttons[kb_up]   | joy_any[joy_up];
		end else begin
			left_raw  = kb_buttons[kb_left]  | joy_any[joy_left];
			right_raw = kb_buttons[kb_right] | joy_any[joy_right];
		end
	end

	// Control word assembly
	always_comb begin
		ctrl_next              = '0;
		ctrl_next[ctl_coin]    = kb_buttons[kb_coin];    // Keyboard only
		ctrl_next[ctl_start1]  = kb_buttons[kb_start1];
		ctrl_next[ctl_start2]  = kb_buttons[kb_start2];
		ctrl_next[ctl_left]    = left_raw;
		ctrl_next[ctl_right]   = right_raw;
		ctrl_next[ctl_fire]    = kb_buttons[kb_fire]    | joy_any[joy_fire];
		ctrl_next[ctl_barrier] = kb_buttons[kb_barrier] | joy_any[joy_barrier];
	end

	// ------------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_ctrl <= '0;
		end else begin
			game_ctrl <= ctrl_next;
		end
	end

endmodule

`default_nettype wire

// ==== src/video_blanker.sv ====
/*
 * Core syncs are active high and come out inverted for the monitor.
 * All five outputs lag the inputs by exactly one clock.
 */
`timescale 1ns/10ps
`default_nettype none

module video_blanker #(
	parameter int COLOR_BITS = arcade_io_pkg::COLOR_BITS
) (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic [COLOR_BITS-1:0] red,
	input  logic [COLOR_BITS-1:0] green,
	input  logic [COLOR_BITS-1:0] blue,
	input  logic                  hsync,
	input  logic                  vsync,
	input  logic                  hblank_bg,
	input  logic                  hblank_fg,
	input  logic                  vblank,
	output logic [COLOR_BITS-1:0] vga_r,
	output logic [COLOR_BITS-1:0] vga_g,
	output logic [COLOR_BITS-1:0] vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs
);

	logic                  blank;
	logic [COLOR_BITS-1:0] r_masked;
	logic [COLOR_BITS-1:0] g_masked;
	logic [COLOR_BITS-1:0] b_masked;

	// ------------------------------------------------------------------------
	// Blank condition
	// ------------------------------------------------------------------------
	// Horizontal blank only counts when both layers agree
	assign blank = (hblank_bg & hblank_fg) | vblank;

	assign r_masked = blank ? '0 : red;
	assign g_masked = blank ? '0 : green;
	assign b_masked = blank ? '0 : blue;

	// ------------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1; // Inactive level after inversion
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= r_masked;
			vga_g  <= g_masked;
			vga_b  <= b_masked;
			vga_hs <= ~hsync;
			vga_vs <= ~vsync;
		end
	end

endmodule

`default_nettype wire

// ==== src/sigma_delta_dac.sv ====
/*
 * Unsigned sample with full scale at 2**AUDIO_BITS - 1.
 * Needs an external RC low-pass on the output pin.
 */
`timescale 1ns/10ps
`default_nettype none

module sigma_delta_dac #(
	parameter int AUDIO_BITS = arcade_io_pkg::AUDIO_BITS
) (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic [AUDIO_BITS-1:0] sample,
	output logic                  dac_out
);

	logic [AUDIO_BITS-1:0] accum;
	logic [AUDIO_BITS:0]   accum_sum; // Extra bit holds the carry

	// ------------------------------------------------------------------------
	// Error accumulator
	// ------------------------------------------------------------------------
	// The remainder wraps around and the carry is the output pulse
	assign accum_sum = {1'b0, accum} + {1'b0, sample};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			accum   <= '0;
			dac_out <= 1'b0;
		end else begin
			accum   <= accum_sum[AUDIO_BITS-1:0];
			dac_out <= accum_sum[AUDIO_BITS]; // One pulse per overflow
		end
	end

endmodule

`default_nettype wire

// ==== src/arcade_io_top.sv ====
/*
 * Single clock domain with all inputs synchronous to clk_sys.
 * Audio is mono, copied to both channels.
 */
`timescale 1ns/10ps
`default_nettype none

module arcade_io_top #(
	parameter int COLOR_BITS = arcade_io_pkg::COLOR_BITS,
	parameter int AUDIO_BITS = arcade_io_pkg::AUDIO_BITS
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	// Keyboard events
	input  logic                      key_strobe,
	input  logic [7:0]                key_code,
	input  logic                      key_pressed,
	// Joysticks and monitor orientation
	input  arcade_io_pkg::joy_t       joystick_0,
	input  arcade_io_pkg::joy_t       joystick_1,
	input  logic                      rotate,
	output arcade_io_pkg::game_ctrl_t game_ctrl,
	// Core video
	input  logic [COLOR_BITS-1:0]     red,
	input  logic [COLOR_BITS-1:0]     green,
	input  logic [COLOR_BITS-1:0]     blue,
	input  logic                      hsync,
	input  logic                      vsync,
	input  logic                      hblank_bg,
	input  logic                      hblank_fg,
	input  logic                      vblank,
	output logic [COLOR_BITS-1:0]     vga_r,
	output logic [COLOR_BITS-1:0]     vga_g,
	output logic [COLOR_BITS-1:0]     vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs,
	// Audio
	input  logic [AUDIO_BITS-1:0]     audio_sample,
	output logic                      audio_l,
	output logic                      audio_r
);

	import arcade_io_pkg::*;

	kb_buttons_t kb_buttons;
	logic        dac_bit;

	// ------------------------------------------------------------------------
	// Input side
	// ------------------------------------------------------------------------
	key_decoder key_decoder_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.kb_buttons  (kb_buttons)
	);

	control_mapper control_mapper_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.kb_buttons (kb_buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.game_ctrl  (game_ctrl)
	);

	// ------------------------------------------------------------------------
	// Video and audio
	// ------------------------------------------------------------------------
	video_blanker #(
		.COLOR_BITS (COLOR_BITS)
	) video_blanker_i (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.hsync     (hsync),
		.vsync     (vsync),
		.hblank_bg (hblank_bg),
		.hblank_fg (hblank_fg),
		.vblank    (vblank),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac #(
		.AUDIO_BITS (AUDIO_BITS)
	) sigma_delta_dac_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.sample  (audio_sample),
		.dac_out (dac_bit)
	);

	assign audio_l = dac_bit; // Same stream on both sides
	assign audio_r = dac_bit;

endmodule

`default_nettype wire

// ==== testbench/arcade_io_asserts.sv ====
/*
 * Bound to arcade_io_top with its color width.
 * Covers reset levels, mono audio and blanking.
 */
`timescale 1ns/10ps
`default_nettype none

module arcade_io_asserts #(
	parameter int COLOR_BITS = arcade_io_pkg::COLOR_BITS
) (
	input logic                      clk_sys,
	input logic                      arst_n,
	input arcade_io_pkg::game_ctrl_t game_ctrl,
	input logic                      audio_l,
	input logic                      audio_r,
	input logic                      hblank_bg,
	input logic                      hblank_fg,
	input logic                      vblank,
	input logic [COLOR_BITS-1:0]     vga_r,
	input logic [COLOR_BITS-1:0]     vga_g,
	input logic [COLOR_BITS-1:0]     vga_b
);

	// Outputs held quiet during reset
	reset_quiet: assert property (@(posedge clk_sys) !arst_n |-> (game_ctrl == '0 && !audio_l))
		else $error("game_ctrl or audio not zero in reset");

	audio_mono: assert property (@(posedge clk_sys) audio_l == audio_r)
		else $error("audio_l and audio_r differ");

	blank_black: assert property (@(posedge clk_sys) disable iff (!arst_n)
		((hblank_bg && hblank_fg) || vblank) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else $error("color not zero after blank");

endmodule

`default_nettype wire

// ==== testbench/arcade_io_tb.sv ====
/*
 * Runs the commands of arcade_io_stimulus.txt from the project root.
 * Default parameters only, 8 ns clock.
 */
`timescale 1ns/10ps
`default_nettype none

module arcade_io_tb;

	import arcade_io_pkg::*;

	logic                  clk_sys = 1'b0;
	logic                  arst_n = 1'b0;
	logic                  key_strobe = 1'b0;
	logic [7:0]            key_code = '0;
	logic                  key_pressed = 1'b0;
	joy_t                  joystick_0 = '0;
	joy_t                  joystick_1 = '0;
	logic                  rotate = 1'b0;
	game_ctrl_t            game_ctrl;
	logic [COLOR_BITS-1:0] red = '0;
	logic [COLOR_BITS-1:0] green = '0;
	logic [COLOR_BITS-1:0] blue = '0;
	logic                  hsync = 1'b0;
	logic                  vsync = 1'b0;
	logic                  hblank_bg = 1'b0;
	logic                  hblank_fg = 1'b0;
	logic                  vblank = 1'b0;
	logic [COLOR_BITS-1:0] vga_r;
	logic [COLOR_BITS-1:0] vga_g;
	logic [COLOR_BITS-1:0] vga_b;
	logic                  vga_hs;
	logic                  vga_vs;
	logic [AUDIO_BITS-1:0] audio_sample = '0;
	logic                  audio_l;
	logic                  audio_r;

	int    mismatches = 0;
	int    other_errors = 0;
	string lines[$];
	bit    loaded = 1'b0;

	arcade_io_top dut_i (.*);

	bind arcade_io_top arcade_io_asserts #(.COLOR_BITS(COLOR_BITS)) asserts_i (
		.clk_sys(clk_sys), .arst_n(arst_n), .game_ctrl(game_ctrl), .audio_l(audio_l),
		.audio_r(audio_r), .hblank_bg(hblank_bg), .hblank_fg(hblank_fg), .vblank(vblank),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b));

	always #4 clk_sys = ~clk_sys;

	// ------------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------------
	task automatic check_ctrl(input game_ctrl_t got, input game_ctrl_t exp);
		if (got !== exp) begin
			$display("Mismatch game_ctrl: got %h expected %h", got, exp);
			mismatches++;
		end
	endtask

	task automatic check_color(input logic [COLOR_BITS-1:0] er, eg, eb, input logic ehs, evs);
		if (vga_r !== er) begin
			$display("Mismatch vga_r: got %h expected %h", vga_r, er);
			mismatches++;
		end
		if (vga_g !== eg) begin
			$display("Mismatch vga_g: got %h expected %h", vga_g, eg);
			mismatches++;
		end
		if (vga_b !== eb) begin
			$display("Mismatch vga_b: got %h expected %h", vga_b, eb);
			mismatches++;
		end
		if ({vga_hs, vga_vs} !== {ehs, evs}) begin
			$display("Mismatch vga_hs/vga_vs: got %h expected %h", {vga_hs, vga_vs}, {ehs, evs});
			mismatches++;
		end
	endtask

	task automatic check_density(input logic [AUDIO_BITS-1:0] smp, input int ones);
		if (ones != int'(smp)) begin
			$display("Mismatch audio_l ones: got %h expected %h", ones, smp);
			mismatches++;
		end
	endtask

	function automatic logic [7:0] code_of(input string name);
		case (name)
			"up":      return sc_up;
			"down":    return sc_down;
			"left":    return sc_left;
			"right":   return sc_right;
			"coin":    return sc_coin;
			"start1":  return sc_start1;
			"start2":  return sc_start2;
			"fire":    return sc_fire;
			"barrier": return sc_barrier;
			default:   return 8'h1c; // Letter A, not mapped
		endcase
	endfunction

	// Random pixel and blanks checked after the register stage
	task automatic drive_random_pixel();
		logic [31:0]           rnd;
		logic [COLOR_BITS-1:0] r;
		logic [COLOR_BITS-1:0] g;
		logic [COLOR_BITS-1:0] b;
		logic                  hs;
		logic                  vs;
		logic                  hb;
		logic                  hf;
		logic                  vb;
		logic                  blank;
		rnd = $urandom;
		r = rnd[COLOR_BITS-1:0];
		g = rnd[2*COLOR_BITS-1:COLOR_BITS];
		b = rnd[3*COLOR_BITS-1:2*COLOR_BITS];
		hs = rnd[3*COLOR_BITS];
		vs = rnd[3*COLOR_BITS+1];
		hb = rnd[3*COLOR_BITS+2];
		hf = rnd[3*COLOR_BITS+3];
		vb = rnd[3*COLOR_BITS+4];
		blank = (hb & hf) | vb; // Both horizontal blanks or the vertical one
		@(posedge clk_sys);
		red       <= r;
		green     <= g;
		blue      <= b;
		hsync     <= hs;
		vsync     <= vs;
		hblank_bg <= hb;
		hblank_fg <= hf;
		vblank    <= vb;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_color(blank ? '0 : r, blank ? '0 : g, blank ? '0 : b, ~hs, ~vs);
	endtask

	// ------------------------------------------------------------------------
	// Command interpreter
	// ------------------------------------------------------------------------
	task automatic execute_command(input string line);
		string       cmd;
		string       name;
		logic [31:0] v[13];
		int          ones;
		void'($sscanf(line, "%s", cmd));
		case (cmd)
			"key": begin
				void'($sscanf(line, "%s %s %h", cmd, name, v[0]));
				@(posedge clk_sys);
				key_strobe  <= 1'b1;
				key_code    <= code_of(name);
				key_pressed <= v[0][0];
				@(posedge clk_sys);
				key_strobe <= 1'b0;
			end
			"joy": begin
				void'($sscanf(line, "%s %h %h", cmd, v[0], v[1]));
				@(posedge clk_sys);
				joystick_0 <= v[0][7:0];
				joystick_1 <= v[1][7:0];
			end
			"rot": begin
				void'($sscanf(line, "%s %h", cmd, v[0]));
				@(posedge clk_sys);
				rotate <= v[0][0];
			end
			"chk": begin
				void'($sscanf(line, "%s %h", cmd, v[0]));
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_ctrl(game_ctrl, v[0][6:0]);
			end
			"vid": begin
				void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", cmd, v[0], v[1],
					v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12]));
				@(posedge clk_sys);
				red       <= v[0][COLOR_BITS-1:0];
				green     <= v[1][COLOR_BITS-1:0];
				blue      <= v[2][COLOR_BITS-1:0];
				hsync     <= v[3][0];
				vsync     <= v[4][0];
				hblank_bg <= v[5][0];
				hblank_fg <= v[6][0];
				vblank    <= v[7][0];
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_color(v[8][COLOR_BITS-1:0], v[9][COLOR_BITS-1:0], v[10][COLOR_BITS-1:0],
					v[11][0], v[12][0]);
				// Idle cycle with random pixel and blanks
				drive_random_pixel();
			end
			"aud": begin
				void'($sscanf(line, "%s %h", cmd, v[0]));
				ones = 0;
				@(posedge clk_sys);
				audio_sample <= v[0][AUDIO_BITS-1:0];
				for (int i = 0; i < (1 << AUDIO_BITS); i++) begin
					@(posedge clk_sys);
					@(negedge clk_sys);
					ones += int'(audio_l);
				end
				check_density(v[0][AUDIO_BITS-1:0], ones);
			end
			default: begin
				$display("Unknown stimulus command: %s", line);
				other_errors++;
			end
		endcase
	endtask

	// Watchdog sized from the number of commands
	initial begin
		real limit_ns;
		wait (loaded);
		limit_ns = real'(lines.size()) * (1 << AUDIO_BITS) * 8.0 + 5000.0;
		#(limit_ns);
		$display("Timeout: simulation did not finish in %0.0f ns", limit_ns);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int    fd;
		string line;
		void'($urandom(54466));
		fd = $fopen("testbench/arcade_io_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			other_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#")
					lines.push_back(line);
			end
			$fclose(fd);
		end
		loaded = 1'b1;

		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);
		// Reset state
		check_ctrl(game_ctrl, '0);
		check_color('0, '0, '0, 1'b1, 1'b1);
		check_density('0, int'(audio_l));

		foreach (lines[i])
			execute_command(lines[i]);

		$display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== arcade_io_top.f ====
src/arcade_io_pkg.sv
src/key_decoder.sv
src/control_mapper.sv
src/video_blanker.sv
src/sigma_delta_dac.sv
src/arcade_io_top.sv
testbench/arcade_io_asserts.sv
testbench/arcade_io_tb.sv

// ==== build.sh ====
#!/bin/sh
# Compile and run the arcade_io_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
	--top-module arcade_io_tb \
	-f arcade_io_top.f \
	-o arcade_io_sim

./obj_dir/arcade_io_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
	exit 0
else
	exit 1
fi

// ==== testbench/arcade_io_stimulus.txt ====
# key <name> <pressed> | joy <j0> <j1> | rot <r> | chk <game_ctrl>  (values hex)
# vid <r> <g> <b> <hs> <vs> <hbg> <hfg> <vb> <exp_r> <exp_g> <exp_b> <exp_hs> <exp_vs> | aud <sample>
chk 00
key coin 1
chk 01
key start1 1
chk 03
key start2 1
chk 07
key coin 0
chk 06
key start1 0
key start2 0
chk 00
key left 1
chk 08
key right 1
chk 18
key fire 1
chk 38
key barrier 1
chk 78
key other 1
chk 78
key left 0
key right 0
key fire 0
key barrier 0
chk 00
key up 1
key down 1
chk 00
rot 1
chk 18
key up 0
chk 08
key down 0
chk 00
joy 04 08
chk 18
rot 0
chk 00
joy 01 02
chk 18
joy 10 00
chk 20
joy 00 20
chk 40
joy 00 00
chk 00
vid 3 2 1 0 0 0 0 0 3 2 1 1 1
vid 3 2 1 1 0 1 0 0 3 2 1 0 1
vid 3 3 3 0 1 1 1 0 0 0 0 1 0
vid 2 1 3 0 0 0 0 1 0 0 0 1 1
vid 1 1 1 0 0 0 1 0 1 1 1 1 1
aud 000
aud 001
aud 800
aud fff
